//--- design/mipsExecPkg.sv
`default_nettype none

package mipsExecPkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////
	localparam int dataWidth    = 32;
	localparam int regCount     = 32;
	localparam int regAddrWidth = 5;
	localparam int apbAddrWidth = 8;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti  = 6'h0A;
	localparam logic [5:0] opSltiu = 6'h0B;
	localparam logic [5:0] opAndi  = 6'h0C;
	localparam logic [5:0] opOri   = 6'h0D;
	localparam logic [5:0] opXori  = 6'h0E;
	localparam logic [5:0] opLui   = 6'h0F;

	// Funct codes under opRType
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2A;
	localparam logic [5:0] fnSltu = 6'h2B;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// Immediate is {rd, shamt, funct} for I-type
	typedef struct packed {
		logic [5:0]              opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} instrT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpE;

	typedef struct packed {
		aluOpE                   aluOp;
		logic                    useImm;
		logic [dataWidth-1:0]    immValue;
		logic [regAddrWidth-1:0] destReg;
		logic                    regWrite;
		logic                    trapOverflow;
		logic                    illegal;
	} decodeT;

	typedef struct packed {
		logic                    en;
		logic [regAddrWidth-1:0] addr;
		logic [dataWidth-1:0]    data;
	} writebackT;

	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] destReg;
		logic [dataWidth-1:0]    data;
		logic                    wrote;
		logic                    overflow;
		logic                    illegal;
	} resultT;

	// APB request from the debugger side
	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [apbAddrWidth-1:0] paddr;
		logic [dataWidth-1:0]    pwdata;
	} apbReqT;

	typedef struct packed {
		logic [dataWidth-1:0] prdata;
		logic                 pready;
		logic                 pslverr;
	} apbRspT;

endpackage

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [mipsExecPkg::regAddrWidth-1:0]    rsAddr,
	input  logic [mipsExecPkg::regAddrWidth-1:0]    rtAddr,
	output logic [mipsExecPkg::dataWidth-1:0]       rsData,
	output logic [mipsExecPkg::dataWidth-1:0]       rtData,
	input  logic [mipsExecPkg::regAddrWidth-1:0]    dbgAddr,
	output logic [mipsExecPkg::dataWidth-1:0]       dbgData,
	input  mipsExecPkg::writebackT                  instrWrite,
	input  mipsExecPkg::writebackT                  dbgWrite,
	output logic                                    dbgWriteBusy
);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	logic [mipsExecPkg::dataWidth-1:0] bank [mipsExecPkg::regCount];

	// Selected write for this edge
	mipsExecPkg::writebackT wrSel;

	// Instruction writeback wins over the debugger
	always_comb
	begin
		if (instrWrite.en)
		begin
			wrSel = instrWrite;
		end
		else
		begin
			wrSel = dbgWrite;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < mipsExecPkg::regCount; i++)
			begin
				bank[i] <= '0;
			end
		end
		else if (wrSel.en && (wrSel.addr != '0))
		begin
			bank[wrSel.addr] <= wrSel.data;
		end
	end

	// Debug write has to wait a cycle
	assign dbgWriteBusy = instrWrite.en && dbgWrite.en;

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// r0 is hardwired to zero on every port
	always_comb
	begin
		if (rsAddr == '0)
		begin
			rsData = '0;
		end
		else
		begin
			rsData = bank[rsAddr];
		end
	end

	always_comb
	begin
		if (rtAddr == '0)
		begin
			rtData = '0;
		end
		else
		begin
			rtData = bank[rtAddr];
		end
	end

	always_comb
	begin
		if (dbgAddr == '0)
		begin
			dbgData = '0;
		end
		else
		begin
			dbgData = bank[dbgAddr];
		end
	end

	// Both write sources must be resolved once out of reset
	wrEnKnown: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({instrWrite.en, dbgWrite.en}));

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  mipsExecPkg::instrT  instr,
	input  logic                instrValid,
	output mipsExecPkg::decodeT decode
);

	logic [15:0]                       imm16;
	logic [mipsExecPkg::dataWidth-1:0] signExt;
	logic [mipsExecPkg::dataWidth-1:0] zeroExt;
	logic                              legal;

	assign imm16   = {instr.rd, instr.shamt, instr.funct};
	assign signExt = {{16{imm16[15]}}, imm16};
	assign zeroExt = {16'b0, imm16};

	always_comb
	begin
		decode         = '0;
		decode.aluOp   = mipsExecPkg::aluAdd;
		decode.destReg = instr.rt;
		decode.useImm  = 1'b1;
		legal          = 1'b1;

		case (instr.opcode)
			mipsExecPkg::opRType:
			begin
				// Shift amount rides in the low immediate bits
				decode.useImm   = 1'b0;
				decode.destReg  = instr.rd;
				decode.immValue = {27'b0, instr.shamt};
				case (instr.funct)
					mipsExecPkg::fnAdd:
					begin
						decode.aluOp        = mipsExecPkg::aluAdd;
						decode.trapOverflow = 1'b1;
					end
					mipsExecPkg::fnAddu: decode.aluOp = mipsExecPkg::aluAdd;
					mipsExecPkg::fnSub:
					begin
						decode.aluOp        = mipsExecPkg::aluSub;
						decode.trapOverflow = 1'b1;
					end
					mipsExecPkg::fnSubu: decode.aluOp = mipsExecPkg::aluSub;
					mipsExecPkg::fnAnd:  decode.aluOp = mipsExecPkg::aluAnd;
					mipsExecPkg::fnOr:   decode.aluOp = mipsExecPkg::aluOr;
					mipsExecPkg::fnXor:  decode.aluOp = mipsExecPkg::aluXor;
					mipsExecPkg::fnNor:  decode.aluOp = mipsExecPkg::aluNor;
					mipsExecPkg::fnSlt:  decode.aluOp = mipsExecPkg::aluSlt;
					mipsExecPkg::fnSltu: decode.aluOp = mipsExecPkg::aluSltu;
					mipsExecPkg::fnSll:  decode.aluOp = mipsExecPkg::aluSll;
					mipsExecPkg::fnSrl:  decode.aluOp = mipsExecPkg::aluSrl;
					mipsExecPkg::fnSra:  decode.aluOp = mipsExecPkg::aluSra;
					default:             legal        = 1'b0;
				endcase
			end
			mipsExecPkg::opAddi:
			begin
				decode.immValue     = signExt;
				decode.trapOverflow = 1'b1;
			end
			mipsExecPkg::opAddiu: decode.immValue = signExt;
			mipsExecPkg::opSlti:
			begin
				decode.aluOp    = mipsExecPkg::aluSlt;
				decode.immValue = signExt;
			end
			mipsExecPkg::opSltiu:
			begin
				// Sign extended, then compared unsigned
				decode.aluOp    = mipsExecPkg::aluSltu;
				decode.immValue = signExt;
			end
			mipsExecPkg::opAndi:
			begin
				decode.aluOp    = mipsExecPkg::aluAnd;
				decode.immValue = zeroExt;
			end
			mipsExecPkg::opOri:
			begin
				decode.aluOp    = mipsExecPkg::aluOr;
				decode.immValue = zeroExt;
			end
			mipsExecPkg::opXori:
			begin
				decode.aluOp    = mipsExecPkg::aluXor;
				decode.immValue = zeroExt;
			end
			mipsExecPkg::opLui:
			begin
				decode.aluOp    = mipsExecPkg::aluLui;
				decode.immValue = {imm16, 16'b0};
			end
			default: legal = 1'b0;
		endcase

		decode.illegal  = instrValid && !legal;
		decode.regWrite = instrValid && legal;
	end

endmodule

`default_nettype wire

//--- design/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input  logic                              clk,
	input  logic                              rst,
	input  mipsExecPkg::decodeT               decode,
	input  logic                              instrValid,
	input  logic [mipsExecPkg::dataWidth-1:0] rsData,
	input  logic [mipsExecPkg::dataWidth-1:0] rtData,
	output mipsExecPkg::writebackT            instrWrite,
	output mipsExecPkg::resultT               result
);

	logic [mipsExecPkg::dataWidth-1:0] opB;
	logic [mipsExecPkg::dataWidth-1:0] sum;
	logic [mipsExecPkg::dataWidth-1:0] diff;
	logic [mipsExecPkg::dataWidth-1:0] aluOut;
	logic [4:0]                        shamt;
	logic                              ovf;
	logic                              ovfTrap;
	logic                              writeEn;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	assign opB   = decode.useImm ? decode.immValue : rtData;
	assign sum   = rsData + opB;
	assign diff  = rsData - opB;
	assign shamt = decode.immValue[4:0];

	always_comb
	begin
		aluOut = sum;
		ovf    = 1'b0;
		case (decode.aluOp)
			mipsExecPkg::aluAdd:
			begin
				aluOut = sum;
				ovf    = (rsData[31] == opB[31]) && (sum[31] != rsData[31]);
			end
			mipsExecPkg::aluSub:
			begin
				aluOut = diff;
				ovf    = (rsData[31] != opB[31]) && (diff[31] != rsData[31]);
			end
			mipsExecPkg::aluAnd:  aluOut = rsData & opB;
			mipsExecPkg::aluOr:   aluOut = rsData | opB;
			mipsExecPkg::aluXor:  aluOut = rsData ^ opB;
			mipsExecPkg::aluNor:  aluOut = ~(rsData | opB);
			mipsExecPkg::aluSlt:  aluOut = {31'b0, $signed(rsData) < $signed(opB)};
			mipsExecPkg::aluSltu: aluOut = {31'b0, rsData < opB};
			// Shifts work on rt, opB is rtData here
			mipsExecPkg::aluSll:  aluOut = opB << shamt;
			mipsExecPkg::aluSrl:  aluOut = opB >> shamt;
			mipsExecPkg::aluSra:  aluOut = $signed(opB) >>> shamt;
			mipsExecPkg::aluLui:  aluOut = opB;
			default:              aluOut = sum;
		endcase
	end

	// Only add, sub and addi turn overflow into a trap
	assign ovfTrap = instrValid && decode.trapOverflow && ovf;
	assign writeEn = instrValid && decode.regWrite && !ovfTrap;

	assign instrWrite.en   = writeEn;
	assign instrWrite.addr = decode.destReg;
	assign instrWrite.data = aluOut;

	//////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result.valid    <= 1'b0;
			result.wrote    <= 1'b0;
			result.overflow <= 1'b0;
			result.illegal  <= 1'b0;
		end
		else
		begin
			result.valid    <= instrValid;
			result.wrote    <= writeEn;
			result.overflow <= ovfTrap;
			result.illegal  <= instrValid && decode.illegal;
		end
		result.destReg <= decode.destReg;
		result.data    <= aluOut;
	end

	// A reported write must come from a clean instruction
	wroteClean: assert property (@(posedge clk) disable iff (rst)
		result.wrote |-> !(result.illegal || result.overflow));

endmodule

`default_nettype wire

//--- design/apbRegAccess.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegAccess (
	input  logic                                 clk,
	input  logic                                 rst,
	input  mipsExecPkg::apbReqT                  apbReq,
	output mipsExecPkg::apbRspT                  apbRsp,
	output logic [mipsExecPkg::regAddrWidth-1:0] dbgAddr,
	input  logic [mipsExecPkg::dataWidth-1:0]    dbgData,
	output mipsExecPkg::writebackT               dbgWrite,
	input  logic                                 dbgWriteBusy
);

	logic access;
	logic addrOk;
	logic stall;

	// Word aligned and below 0x80 means 0x00 to 0x7C
	assign addrOk  = (apbReq.paddr[7] == 1'b0) && (apbReq.paddr[1:0] == 2'b00);
	assign access  = apbReq.psel && apbReq.penable;
	assign dbgAddr = apbReq.paddr[6:2];

	//////////////////////////////////////////////////
	// Debug write request
	//////////////////////////////////////////////////

	assign dbgWrite.en   = access && apbReq.pwrite && addrOk;
	assign dbgWrite.addr = apbReq.paddr[6:2];
	assign dbgWrite.data = apbReq.pwdata;

	// Wait state while an instruction owns the write port
	assign stall = dbgWrite.en && dbgWriteBusy;

	//////////////////////////////////////////////////
	// Response
	//////////////////////////////////////////////////

	assign apbRsp.pready  = access && !stall;
	assign apbRsp.pslverr = access && !addrOk;
	assign apbRsp.prdata  = (access && !apbReq.pwrite && addrOk) ? dbgData : '0;

	penableNeedsPsel: assert property (@(posedge clk) disable iff (rst)
		apbReq.penable |-> apbReq.psel);

	// Master must hold the transfer through wait states
	holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
		(access && !apbRsp.pready) |=> $stable(apbReq));

endmodule

`default_nettype wire

//--- design/mipsExecCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecCore (
	input  logic                clk,
	input  logic                rst,
	input  mipsExecPkg::instrT  instr,
	input  logic                instrValid,
	output mipsExecPkg::resultT result,
	input  mipsExecPkg::apbReqT apbReq,
	output mipsExecPkg::apbRspT apbRsp
);

	logic [mipsExecPkg::dataWidth-1:0]    rsData;
	logic [mipsExecPkg::dataWidth-1:0]    rtData;
	logic [mipsExecPkg::regAddrWidth-1:0] dbgAddr;
	logic [mipsExecPkg::dataWidth-1:0]    dbgData;
	logic                                 dbgWriteBusy;
	mipsExecPkg::decodeT                  decode;
	mipsExecPkg::writebackT               instrWrite;
	mipsExecPkg::writebackT               dbgWrite;

	//////////////////////////////////////////////////
	// Decode and register read side by side
	//////////////////////////////////////////////////

	registerFile regFile (
		.clk          (clk),
		.rst          (rst),
		.rsAddr       (instr.rs),
		.rtAddr       (instr.rt),
		.rsData       (rsData),
		.rtData       (rtData),
		.dbgAddr      (dbgAddr),
		.dbgData      (dbgData),
		.instrWrite   (instrWrite),
		.dbgWrite     (dbgWrite),
		.dbgWriteBusy (dbgWriteBusy)
	);

	instrDecoder decoder (
		.instr      (instr),
		.instrValid (instrValid),
		.decode     (decode)
	);

	executeUnit execUnit (
		.clk        (clk),
		.rst        (rst),
		.decode     (decode),
		.instrValid (instrValid),
		.rsData     (rsData),
		.rtData     (rtData),
		.instrWrite (instrWrite),
		.result     (result)
	);

	// Debugger access
	apbRegAccess apbAccess (
		.clk          (clk),
		.rst          (rst),
		.apbReq       (apbReq),
		.apbRsp       (apbRsp),
		.dbgAddr      (dbgAddr),
		.dbgData      (dbgData),
		.dbgWrite     (dbgWrite),
		.dbgWriteBusy (dbgWriteBusy)
	);

endmodule

`default_nettype wire

//--- dv/mipsExecTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecTb;

	localparam int clkPeriod     = 40;
	localparam int numRand       = 40;
	localparam int burstLen      = 12;
	// About 300 APB transfers of four cycles each, plus instruction bursts and drains
	localparam int apbTransfers  = 300;
	localparam int instrCycles   = 2 * numRand + 8 + burstLen + 40;
	localparam int timeoutCycles = 3 + 4 * apbTransfers + instrCycles + 200;

	logic                clk;
	logic                rst;
	mipsExecPkg::instrT  instr;
	logic                instrValid;
	mipsExecPkg::resultT result;
	mipsExecPkg::apbReqT apbReq;
	mipsExecPkg::apbRspT apbRsp;

	logic [31:0]         model [32];
	mipsExecPkg::resultT expQ [$];
	mipsExecPkg::resultT expNow;
	int                  errorCount  = 0;
	int                  checkCount  = 0;
	int                  testsRun    = 0;
	int                  testsFailed = 0;

	mipsExecCore u_dut (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.result     (result),
		.apbReq     (apbReq),
		.apbRsp     (apbRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic addOverflows(input logic [31:0] a, input logic [31:0] b);
		longint s;
		s = longint'($signed(a)) + longint'($signed(b));
		return (s > 64'sd2147483647) || (s < -64'sd2147483648);
	endfunction

	function automatic logic subOverflows(input logic [31:0] a, input logic [31:0] b);
		longint s;
		s = longint'($signed(a)) - longint'($signed(b));
		return (s > 64'sd2147483647) || (s < -64'sd2147483648);
	endfunction

	// Expected outcome of one instruction, updates the model on a write
	function automatic mipsExecPkg::resultT computeExpected(input mipsExecPkg::instrT ins);
		mipsExecPkg::resultT r;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         sext;
		logic [31:0]         zext;
		logic [31:0]         val;
		logic [15:0]         imm16;
		logic [4:0]          dest;
		logic                known;
		logic                trap;
		a     = model[ins.rs];
		b     = model[ins.rt];
		imm16 = {ins.rd, ins.shamt, ins.funct};
		sext  = {{16{imm16[15]}}, imm16};
		zext  = {16'h0000, imm16};
		val   = '0;
		dest  = ins.rt;
		known = 1'b1;
		trap  = 1'b0;
		case (ins.opcode)
			mipsExecPkg::opRType:
			begin
				dest = ins.rd;
				case (ins.funct)
					mipsExecPkg::fnAdd:
					begin
						val  = a + b;
						trap = addOverflows(a, b);
					end
					mipsExecPkg::fnAddu: val = a + b;
					mipsExecPkg::fnSub:
					begin
						val  = a - b;
						trap = subOverflows(a, b);
					end
					mipsExecPkg::fnSubu: val = a - b;
					mipsExecPkg::fnAnd:  val = a & b;
					mipsExecPkg::fnOr:   val = a | b;
					mipsExecPkg::fnXor:  val = a ^ b;
					mipsExecPkg::fnNor:  val = ~(a | b);
					mipsExecPkg::fnSlt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mipsExecPkg::fnSltu: val = (a < b) ? 32'd1 : 32'd0;
					mipsExecPkg::fnSll:  val = b << ins.shamt;
					mipsExecPkg::fnSrl:  val = b >> ins.shamt;
					mipsExecPkg::fnSra:  val = $signed(b) >>> ins.shamt;
					default:             known = 1'b0;
				endcase
			end
			mipsExecPkg::opAddi:
			begin
				val  = a + sext;
				trap = addOverflows(a, sext);
			end
			mipsExecPkg::opAddiu: val = a + sext;
			mipsExecPkg::opSlti:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			// Unsigned compare against the sign-extended immediate
			mipsExecPkg::opSltiu: val = (a < sext) ? 32'd1 : 32'd0;
			mipsExecPkg::opAndi:  val = a & zext;
			mipsExecPkg::opOri:   val = a | zext;
			mipsExecPkg::opXori:  val = a ^ zext;
			mipsExecPkg::opLui:   val = {imm16, 16'h0000};
			default:              known = 1'b0;
		endcase
		r          = '0;
		r.valid    = 1'b1;
		r.destReg  = dest;
		r.data     = val;
		r.illegal  = !known;
		r.overflow = known && trap;
		r.wrote    = known && !trap;
		if (r.wrote && (dest != 5'd0))
		begin
			model[dest] = val;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic reportMismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		errorCount++;
		$display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
			$time, sig, got, exp);
	endtask

	// Destination and data only matter when the write happened
	task automatic checkResult(input mipsExecPkg::resultT got, input mipsExecPkg::resultT exp);
		checkCount++;
		if (got.valid !== exp.valid)
			reportMismatch("result.valid", 32'(got.valid), 32'(exp.valid));
		if (got.wrote !== exp.wrote)
			reportMismatch("result.wrote", 32'(got.wrote), 32'(exp.wrote));
		if (got.overflow !== exp.overflow)
			reportMismatch("result.overflow", 32'(got.overflow), 32'(exp.overflow));
		if (got.illegal !== exp.illegal)
			reportMismatch("result.illegal", 32'(got.illegal), 32'(exp.illegal));
		if (exp.wrote && (got.destReg !== exp.destReg))
			reportMismatch("result.destReg", 32'(got.destReg), 32'(exp.destReg));
		if (exp.wrote && (got.data !== exp.data))
			reportMismatch("result.data", got.data, exp.data);
	endtask

	task automatic checkApbRead(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checkCount++;
		if (got !== exp)
			reportMismatch(what, got, exp);
	endtask

	task automatic checkSlverr(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp)
			reportMismatch(what, 32'(got), 32'(exp));
	endtask

	// Result compare, sampled mid-cycle where result is stable
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (result.valid === 1'b1)
			begin
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("result.valid was high at %0t ns with no instruction outstanding",
						$time);
				end
				else
				begin
					expNow = expQ.pop_front();
					checkResult(result, expNow);
				end
			end
			// Only the instruction driven on the last edge may still be waiting
			if (expQ.size() > ((instrValid === 1'b1) ? 1 : 0))
			begin
				errorCount++;
				$display("No result at %0t ns for the instruction sampled on the last edge",
					$time);
				expNow = expQ.pop_front();
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic apbTransfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr,
		output int waits);
		waits = 0;
		@(posedge clk);
		apbReq.psel    <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite  <= write;
		apbReq.paddr   <= addr;
		apbReq.pwdata  <= wdata;
		@(posedge clk);
		apbReq.penable <= 1'b1;
		@(negedge clk);
		while (!apbRsp.pready)
		begin
			waits++;
			@(negedge clk);
		end
		rdata  = apbRsp.prdata;
		slverr = apbRsp.pslverr;
		@(posedge clk);
		apbReq.psel    <= 1'b0;
		apbReq.penable <= 1'b0;
	endtask

	task automatic writeReg(input int n, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		int          waits;
		apbTransfer(1'b1, 8'(n * 4), data, rdata, err, waits);
		checkSlverr(err, 1'b0, $sformatf("pslverr on write to reg %0d", n));
		if (n != 0)
		begin
			model[n] = data;
		end
	endtask

	task automatic verifyAllRegs();
		logic [31:0] rdata;
		logic        err;
		int          waits;
		for (int n = 0; n < 32; n++)
		begin
			apbTransfer(1'b0, 8'(n * 4), 32'h0, rdata, err, waits);
			checkApbRead(rdata, model[n], $sformatf("prdata reg %0d", n));
			checkSlverr(err, 1'b0, $sformatf("pslverr on read of reg %0d", n));
		end
	endtask

	task automatic issueInstr(input mipsExecPkg::instrT ins);
		@(posedge clk);
		instr      <= ins;
		instrValid <= 1'b1;
		expQ.push_back(computeExpected(ins));
	endtask

	task automatic stopInstr();
		@(posedge clk);
		instr      <= '0;
		instrValid <= 1'b0;
	endtask

	task automatic drainResults();
		int n;
		n = 0;
		while ((expQ.size() != 0) && (n < 8))
		begin
			@(negedge clk);
			n++;
		end
		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("%0d instruction results never appeared on result", expQ.size());
			expQ.delete();
		end
	endtask

	function automatic logic [5:0] rFunct(input int k);
		case (k)
			0:       return mipsExecPkg::fnAdd;
			1:       return mipsExecPkg::fnAddu;
			2:       return mipsExecPkg::fnSub;
			3:       return mipsExecPkg::fnSubu;
			4:       return mipsExecPkg::fnAnd;
			5:       return mipsExecPkg::fnOr;
			6:       return mipsExecPkg::fnXor;
			7:       return mipsExecPkg::fnNor;
			8:       return mipsExecPkg::fnSlt;
			9:       return mipsExecPkg::fnSltu;
			10:      return mipsExecPkg::fnSll;
			11:      return mipsExecPkg::fnSrl;
			default: return mipsExecPkg::fnSra;
		endcase
	endfunction

	function automatic mipsExecPkg::instrT makeR(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {mipsExecPkg::opRType, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mipsExecPkg::instrT makeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic reportTest(input string name, input int startErr);
		testsRun++;
		if (errorCount == startErr)
		begin
			$display("Test %0d %s: pass", testsRun, name);
		end
		else
		begin
			testsFailed++;
			$display("Test %0d %s: FAIL with %0d errors",
				testsRun, name, errorCount - startErr);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		int                 startErr;
		int                 waits;
		logic [31:0]        rdata;
		logic               err;
		logic [4:0]         prevRd;
		logic [15:0]        imm;
		mipsExecPkg::instrT ins;

		void'($urandom(5216));
		instr      = '0;
		instrValid = 1'b0;
		apbReq     = '0;
		rst        = 1'b1;
		prevRd     = 5'd1;
		for (int n = 0; n < 32; n++)
		begin
			model[n] = '0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// 1 Reset state
		startErr = errorCount;
		@(negedge clk);
		if (result.valid !== 1'b0)
		begin
			reportMismatch("result.valid", 32'(result.valid), 32'd0);
		end
		verifyAllRegs();
		reportTest("reset state", startErr);

		// 2 Debug writes and bad addresses
		startErr = errorCount;
		for (int n = 0; n < 32; n++)
		begin
			writeReg(n, (32'(n) * 32'h01030507) ^ 32'h5A5A5A5A);
		end
		verifyAllRegs();
		apbTransfer(1'b1, 8'h41, 32'hDEADBEEF, rdata, err, waits);
		checkSlverr(err, 1'b1, "pslverr on write to 0x41");
		apbTransfer(1'b1, 8'h80, 32'hDEADBEEF, rdata, err, waits);
		checkSlverr(err, 1'b1, "pslverr on write to 0x80");
		apbTransfer(1'b0, 8'h80, 32'h0, rdata, err, waits);
		checkSlverr(err, 1'b1, "pslverr on read of 0x80");
		checkApbRead(rdata, 32'h0, "prdata from 0x80");
		verifyAllRegs();
		reportTest("apb access", startErr);

		// 3 Random R-type, odd steps depend on the previous destination
		startErr = errorCount;
		for (int n = 1; n < 32; n++)
		begin
			writeReg(n, $urandom);
		end
		for (int i = 0; i < numRand; i++)
		begin
			ins = makeR(rFunct(i % 13), 5'($urandom), 5'($urandom),
				5'($urandom_range(1, 31)), 5'($urandom));
			if (i % 2 == 1)
			begin
				ins.rs = prevRd;
			end
			prevRd = ins.rd;
			issueInstr(ins);
		end
		stopInstr();
		drainResults();
		verifyAllRegs();
		reportTest("random r-type", startErr);

		// 4 Every I-type opcode, each with both immediate signs
		startErr = errorCount;
		for (int i = 0; i < numRand; i++)
		begin
			imm     = 16'($urandom);
			imm[15] = i[0];
			ins     = makeI(mipsExecPkg::opAddi + 6'((i / 2) % 8), 5'($urandom),
				5'($urandom_range(1, 31)), imm);
			issueInstr(ins);
		end
		stopInstr();
		drainResults();
		verifyAllRegs();
		reportTest("random i-type", startErr);

		// 5 Overflow traps and illegal codes
		startErr = errorCount;
		writeReg(1, 32'h7FFFFFFF);
		writeReg(2, 32'h00000001);
		writeReg(3, 32'h80000000);
		for (int n = 4; n < 8; n++)
		begin
			writeReg(n, 32'h0BAD0000 | 32'(n));
		end
		issueInstr(makeR(mipsExecPkg::fnAdd, 5'd1, 5'd2, 5'd4, 5'd0));
		issueInstr(makeR(mipsExecPkg::fnSub, 5'd3, 5'd2, 5'd5, 5'd0));
		issueInstr(makeI(mipsExecPkg::opAddi, 5'd1, 5'd6, 16'h0001));
		issueInstr(makeI(mipsExecPkg::opAddi, 5'd3, 5'd7, 16'hFFFF));
		for (int i = 0; i < 6; i++)
		begin
			issueInstr(makeI(6'($urandom_range(16, 63)), 5'($urandom), 5'($urandom),
				16'($urandom)));
		end
		issueInstr(makeR(6'h01, 5'd1, 5'd2, 5'd8, 5'd0));
		issueInstr(makeR(6'h3F, 5'd1, 5'd2, 5'd9, 5'd0));
		stopInstr();
		drainResults();
		verifyAllRegs();
		reportTest("overflow and illegal", startErr);

		// 6 Debug write against a full writeback burst, both hit reg 9
		startErr = errorCount;
		fork
			begin
				for (int i = 0; i < burstLen; i++)
				begin
					issueInstr(makeR(mipsExecPkg::fnAddu, 5'($urandom), 5'($urandom),
						(i % 3 == 0) ? 5'd9 : 5'($urandom_range(10, 31)), 5'd0));
				end
				stopInstr();
			end
			apbTransfer(1'b1, 8'(9 * 4), 32'hC0FFEE09, rdata, err, waits);
		join
		model[9] = 32'hC0FFEE09;
		checkSlverr(err, 1'b0, "pslverr on stalled write");
		// Access phase starts one cycle into the burst
		if (waits != burstLen - 1)
		begin
			errorCount++;
			$display("APB write waited %0d cycles behind the instruction burst, expected %0d",
				waits, burstLen - 1);
		end
		drainResults();
		verifyAllRegs();
		reportTest("write stall", startErr);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		#(timeoutCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles before the tests finished",
			timeoutCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsExec.f
design/mipsExecPkg.sv
design/registerFile.sv
design/instrDecoder.sv
design/executeUnit.sv
design/apbRegAccess.sv
design/mipsExecCore.sv
dv/mipsExecTb.sv

//--- Makefile
# Verilator build and run for the mipsExec core

VERILATOR ?= verilator
TOP       ?= mipsExecTb
FILELIST  ?= mipsExec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
